// File: decoder.sv
`timescale 1ns/1ns

module decoder (
    input  logic [rv_pkg::xlen-1:0]      instr,
    input  logic [rv_pkg::pc_width-1:0]  instr_pc,
    output rv_pkg::decoded_t             dec
);
    import rv_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediates for each format.
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};

    always_comb begin
        dec     = '0;
        dec.op  = op_nop;
        dec.alu = alu_add;
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd  = instr[11:7];
        dec.pc  = instr_pc;

        case (opcode)
            opc_op: begin
                dec.writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: begin dec.op = op_add; dec.alu = alu_add; end
                    {7'b0100000, 3'b000}: begin dec.op = op_sub; dec.alu = alu_sub; end
                    {7'b0000000, 3'b111}: begin dec.op = op_and; dec.alu = alu_and; end
                    {7'b0000000, 3'b110}: begin dec.op = op_or;  dec.alu = alu_or;  end
                    {7'b0000000, 3'b100}: begin dec.op = op_xor; dec.alu = alu_xor; end
                    {7'b0000000, 3'b010}: begin dec.op = op_slt; dec.alu = alu_slt; end
                    default: dec.writes_rd = 1'b0;
                endcase
            end
            opc_op_imm: begin
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
                case (funct3)
                    3'b000: begin dec.op = op_addi; dec.alu = alu_add; end
                    3'b111: begin dec.op = op_andi; dec.alu = alu_and; end
                    3'b110: begin dec.op = op_ori;  dec.alu = alu_or;  end
                    3'b100: begin dec.op = op_xori; dec.alu = alu_xor; end
                    default: dec.writes_rd = 1'b0;
                endcase
            end
            opc_lui: begin
                dec.op        = op_lui;
                dec.alu       = alu_pass_b;
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            opc_branch: begin
                // Only beq and bne; the compare lives in execute.
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    dec.op        = (funct3 == 3'b001) ? op_bne : op_beq;
                    dec.imm       = imm_b;
                    dec.is_branch = 1'b1;
                    dec.branch_ne = funct3[0];
                end
            end
            opc_store: begin
                if (funct3 == 3'b010) begin
                    dec.op       = op_sw;
                    dec.imm      = imm_s;
                    dec.use_imm  = 1'b1;
                    dec.is_store = 1'b1;
                end
            end
            opc_system: begin
                if (instr == ebreak_instr) begin
                    dec.op      = op_ebreak;
                    dec.is_halt = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  rv_pkg::decoded_t             dec,
    input  logic [rv_pkg::xlen-1:0]      rdata1,
    input  logic [rv_pkg::xlen-1:0]      rdata2,
    output logic [4:0]                   raddr1,
    output logic [4:0]                   raddr2,
    input  rv_pkg::wb_t                  wb_fwd,
    output logic                         redirect,
    output logic [rv_pkg::pc_width-1:0]  redirect_pc,
    output logic                         halt_req,
    output rv_pkg::wb_t                  wb_next
);
    import rv_pkg::*;

    logic            squash_q;
    logic            slot_valid;
    logic            fwd_ok;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic            operands_eq;

    assign raddr1 = dec.rs1;
    assign raddr2 = dec.rs2;

    // The slot after a taken branch or an ebreak never takes effect.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            squash_q <= 1'b0;
        end else begin
            squash_q <= redirect | halt_req;
        end
    end

    assign slot_valid = !squash_q && (dec.op != op_nop);

    // Writeback holds the previous instruction, which the register file
    // has not stored yet.
    assign fwd_ok = wb_fwd.valid && wb_fwd.writes_rd && (wb_fwd.rd != 5'd0);
    assign op_a   = (fwd_ok && wb_fwd.rd == dec.rs1) ? wb_fwd.result : rdata1;
    assign op_b   = (fwd_ok && wb_fwd.rd == dec.rs2) ? wb_fwd.result : rdata2;
    assign alu_b  = dec.use_imm ? dec.imm : op_b;

    always_comb begin
        case (dec.alu)
            alu_add:    alu_result = op_a + alu_b;
            alu_sub:    alu_result = op_a - alu_b;
            alu_and:    alu_result = op_a & alu_b;
            alu_or:     alu_result = op_a | alu_b;
            alu_xor:    alu_result = op_a ^ alu_b;
            alu_slt:    alu_result = {31'd0, $signed(op_a) < $signed(alu_b)};
            alu_pass_b: alu_result = alu_b;
            default:    alu_result = '0;
        endcase
    end

    // Branch target counts in words.
    assign operands_eq = (op_a == op_b);
    assign redirect    = slot_valid && dec.is_branch && (operands_eq ^ dec.branch_ne);
    assign redirect_pc = dec.pc + dec.imm[pc_width+1:2];
    assign halt_req    = slot_valid && dec.is_halt;

    always_comb begin
        wb_next            = '0;
        wb_next.valid      = slot_valid && (dec.writes_rd || dec.is_store);
        wb_next.writes_rd  = dec.writes_rd;
        wb_next.rd         = dec.rd;
        wb_next.result     = alu_result;
        wb_next.is_store   = dec.is_store;
        wb_next.store_data = op_b;
    end

    a_store_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (slot_valid && dec.is_store) |-> (alu_result[1:0] == 2'b00)
    ) else $error("misaligned store address %h", alu_result);

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         redirect,
    input  logic [rv_pkg::pc_width-1:0]  redirect_pc,
    input  logic                         halt_req,
    output logic [rv_pkg::xlen-1:0]      instr,
    output logic [rv_pkg::pc_width-1:0]  instr_pc,
    output logic                         halted
);
    import rv_pkg::*;

    logic [xlen-1:0]     imem [imem_words];
    logic [pc_width-1:0] pc;

    initial begin
        $readmemh(program_file, imem);
    end

    // One word per cycle into the fetch slot.
    // A redirect or a halt replaces the slot with a nop.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            instr    <= nop_instr;
            instr_pc <= '0;
            halted   <= 1'b0;
        end else if (halt_req || halted) begin
            // Frozen until reset.
            instr  <= nop_instr;
            halted <= 1'b1;
        end else if (redirect) begin
            pc       <= redirect_pc;
            instr    <= nop_instr;
            instr_pc <= pc;
        end else begin
            instr    <= imem[pc];
            instr_pc <= pc;
            pc       <= pc + pc_width'(1);
        end
    end

    // Execute resolves at most one control event per slot.
    a_redirect_halt_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(redirect && halt_req)
    ) else $error("redirect and halt_req asserted together");

endmodule

// File: program.mem
// One 32-bit instruction word per line in hex, starting at word address 0.
// Stores go to 0x100 per section: reg-reg, immediates, forwarding, branches, x0.
ff900093  // addi x1, x0, -7
00c00113  // addi x2, x0, 12
002081b3  // add  x3, x1, x2
10302023  // sw   x3, 0x100(x0)
40208233  // sub  x4, x1, x2
10402223  // sw   x4, 0x104(x0)
0020f2b3  // and  x5, x1, x2
10502423  // sw   x5, 0x108(x0)
0020e333  // or   x6, x1, x2
10602623  // sw   x6, 0x10c(x0)
0020c3b3  // xor  x7, x1, x2
10702823  // sw   x7, 0x110(x0)
0020a433  // slt  x8, x1, x2
001124b3  // slt  x9, x2, x1
10802a23  // sw   x8, 0x114(x0)
10902c23  // sw   x9, 0x118(x0)
0f00f513  // andi x10, x1, 0x0f0
f0016593  // ori  x11, x2, -256
fff0c613  // xori x12, x1, -1
abcde6b7  // lui  x13, 0xabcde
fff68693  // addi x13, x13, -1
20a02023  // sw   x10, 0x200(x0)
20b02223  // sw   x11, 0x204(x0)
20c02423  // sw   x12, 0x208(x0)
20d02623  // sw   x13, 0x20c(x0)
00500713  // addi x14, x0, 5
00770713  // addi x14, x14, 7
fec70713  // addi x14, x14, -20
30e02023  // sw   x14, 0x300(x0)
30000793  // addi x15, x0, 0x300
00e7a223  // sw   x14, 4(x15)
00108463  // beq  x1, x1, +8 (taken)
40102023  // sw   x1, 0x400(x0) (skipped)
00209463  // bne  x1, x2, +8 (taken)
40202223  // sw   x2, 0x404(x0) (skipped)
00208463  // beq  x1, x2, +8 (not taken)
40302423  // sw   x3, 0x408(x0)
00211463  // bne  x2, x2, +8 (not taken)
40402623  // sw   x4, 0x40c(x0)
06300013  // addi x0, x0, 99
00208033  // add  x0, x1, x2
50002023  // sw   x0, 0x500(x0)
00100893  // addi x17, x0, 1
51102223  // sw   x17, 0x504(x0)
00100073  // ebreak
50102423  // sw   x1, 0x508(x0) (never executes)

// File: reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [4:0]               raddr1,
    input  logic [4:0]               raddr2,
    output logic [rv_pkg::xlen-1:0]  rdata1,
    output logic [rv_pkg::xlen-1:0]  rdata2,
    input  logic                     we,
    input  logic [4:0]               waddr,
    input  logic [rv_pkg::xlen-1:0]  wdata
);
    import rv_pkg::*;

    // x0 has no storage.
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Plain reads; a same-cycle write is covered by forwarding in execute.
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// File: run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f src.f

./obj_dir/Vtb_rv_core > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"

// File: rv_core.sv
`timescale 1ns/1ns

module rv_core (
    input  logic            clk,
    input  logic            rst_n,
    output rv_pkg::store_t  store,
    output logic            halted
);
    import rv_pkg::*;

    logic [xlen-1:0]     instr;
    logic [pc_width-1:0] instr_pc;
    decoded_t            dec;
    logic [4:0]          raddr1;
    logic [4:0]          raddr2;
    logic [xlen-1:0]     rdata1;
    logic [xlen-1:0]     rdata2;
    logic                redirect;
    logic [pc_width-1:0] redirect_pc;
    logic                halt_req;
    wb_t                 wb_next;
    wb_t                 wb_fwd;
    logic                rf_we;
    logic [4:0]          rf_waddr;
    logic [xlen-1:0]     rf_wdata;

    fetch_unit i_fetch (
        .clk, .rst_n, .redirect, .redirect_pc, .halt_req,
        .instr, .instr_pc, .halted
    );

    decoder i_decoder (.instr, .instr_pc, .dec);

    reg_file i_reg_file (
        .clk, .rst_n, .raddr1, .raddr2, .rdata1, .rdata2,
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    execute_stage i_execute (
        .clk, .rst_n, .dec, .rdata1, .rdata2, .raddr1, .raddr2,
        .wb_fwd, .redirect, .redirect_pc, .halt_req, .wb_next
    );

    writeback_unit i_writeback (
        .clk, .rst_n, .wb_next, .wb_fwd, .rf_we, .rf_waddr, .rf_wdata, .store
    );

endmodule

// File: rv_pkg.sv
package rv_pkg;

    // Datapath and memory sizing.
    localparam int xlen = 32;
    localparam int imem_words = 64;
    localparam int pc_width = 6;
    localparam string program_file = "program.mem";

    // addi x0, x0, 0 fills squashed fetch slots.
    localparam logic [31:0] nop_instr = 32'h0000_0013;
    localparam logic [31:0] ebreak_instr = 32'h0010_0073;

    // Major opcode field, bits 6:0 of the instruction word.
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_store  = 7'b0100011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        op_nop,
        op_add, op_sub, op_and, op_or, op_xor, op_slt,
        op_addi, op_andi, op_ori, op_xori,
        op_lui,
        op_beq, op_bne,
        op_sw,
        op_ebreak
    } op_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
    } alu_e;

    // Output of the decoder for the instruction in the fetch slot.
    typedef struct packed {
        op_e                  op;
        alu_e                 alu;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic [xlen-1:0]      imm;
        logic                 use_imm;
        logic                 writes_rd;
        logic                 is_store;
        logic                 is_branch;
        logic                 branch_ne;
        logic                 is_halt;
        logic [pc_width-1:0]  pc;
    } decoded_t;

    // Execute result on its way to the register file or the store port.
    typedef struct packed {
        logic             valid;
        logic             writes_rd;
        logic [4:0]       rd;
        logic [xlen-1:0]  result;
        logic             is_store;
        logic [xlen-1:0]  store_data;
    } wb_t;

    typedef struct packed {
        logic             we;
        logic [29:0]      addr;
        logic [xlen-1:0]  data;
    } store_t;

endpackage

// File: src.f
rv_pkg.sv
fetch_unit.sv
reg_file.sv
decoder.sv
execute_stage.sv
writeback_unit.sv
rv_core.sv
tb_rv_core.sv

// File: tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;
    import rv_pkg::*;

    logic   clk;
    logic   rst_n;
    store_t store;
    logic   halted;

    // Program image and expected stores from the golden model.
    logic [xlen-1:0] prog [imem_words];
    logic [29:0]     exp_addr [64];
    logic [xlen-1:0] exp_data [64];
    logic [6:0]      exp_count = 7'd0;
    logic [6:0]      store_idx = 7'd0;
    logic [29:0]     head_addr;
    logic [xlen-1:0] head_data;

    int sec_exp [8];
    int sec_seen [8];
    int sec_fail [8];
    int fail_count = 0;
    int halt_fail = 0;
    int prog_len = 0;
    int timeout_limit = 0;
    int cycle_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    rv_core i_dut (
        .clk(clk),
        .rst_n(rst_n),
        .store(store),
        .halted(halted)
    );

    always #50 clk = ~clk;

    // Sections are told apart by bits 8:6 of the word address (byte 0x100 per section).
    function automatic logic [2:0] section_of(input logic [29:0] waddr);
        if (waddr[29:9] != '0) begin
            return 3'd0;
        end
        return waddr[8:6];
    endfunction

    function automatic string section_name(input logic [2:0] s);
        case (s)
            3'd1: return "register-register ops";
            3'd2: return "immediate ops and lui";
            3'd3: return "forwarding chain";
            3'd4: return "taken and not-taken branches";
            3'd5: return "writes to x0";
            default: return "unknown section";
        endcase
    endfunction

    // Sequential ISA interpreter that predicts every store in program order.
    task run_golden();
        logic [xlen-1:0] gregs [32];
        logic [xlen-1:0] pc;
        logic [xlen-1:0] next_pc;
        logic [xlen-1:0] iw;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        logic [xlen-1:0] addr;
        logic [4:0]      rd;
        logic            wr;
        logic            done;
        for (int i = 0; i < 32; i++) begin
            gregs[i[4:0]] = '0;
        end
        pc = '0;
        done = 1'b0;
        while (!done && prog_len < 256) begin
            iw      = prog[pc[7:2]];
            rd      = iw[11:7];
            a       = gregs[iw[19:15]];
            b       = gregs[iw[24:20]];
            wr      = 1'b0;
            res     = '0;
            next_pc = pc + 32'd4;
            case (iw[6:0])
                7'h33: begin
                    wr = 1'b1;
                    case ({iw[31:25], iw[14:12]})
                        10'h000: res = a + b;
                        10'h100: res = a - b;
                        10'h007: res = a & b;
                        10'h006: res = a | b;
                        10'h004: res = a ^ b;
                        10'h002: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                7'h13: begin
                    wr = 1'b1;
                    case (iw[14:12])
                        3'b000: res = a + {{20{iw[31]}}, iw[31:20]};
                        3'b111: res = a & {{20{iw[31]}}, iw[31:20]};
                        3'b110: res = a | {{20{iw[31]}}, iw[31:20]};
                        3'b100: res = a ^ {{20{iw[31]}}, iw[31:20]};
                        default: wr = 1'b0;
                    endcase
                end
                7'h37: begin
                    wr  = 1'b1;
                    res = {iw[31:12], 12'h000};
                end
                7'h63: begin
                    if ((iw[14:12] == 3'b000 && a == b) || (iw[14:12] == 3'b001 && a != b)) begin
                        next_pc = pc + {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
                    end
                end
                7'h23: begin
                    if (iw[14:12] == 3'b010) begin
                        addr = a + {{20{iw[31]}}, iw[31:25], iw[11:7]};
                        exp_addr[exp_count[5:0]] = addr[31:2];
                        exp_data[exp_count[5:0]] = b;
                        exp_count = exp_count + 7'd1;
                        sec_exp[section_of(addr[31:2])]++;
                    end
                end
                7'h73: done = (iw == 32'h0010_0073);
                default: ;
            endcase
            if (wr && rd != 5'd0) begin
                gregs[rd] = res;
            end
            pc = next_pc;
            prog_len++;
        end
    endtask

    assign head_addr = exp_addr[store_idx[5:0]];
    assign head_data = exp_data[store_idx[5:0]];

    // Advances the expected-store head on each store strobe.
    always @(posedge clk) begin
        if (rst_n && store.we) begin
            store_idx <= store_idx + 7'd1;
            sec_seen[section_of(store.addr)] <= sec_seen[section_of(store.addr)] + 1;
        end
    end

    a_store_expected: assert property (
        @(posedge clk) disable iff (!rst_n)
        store.we |-> (store_idx < exp_count)
    ) else begin
        fail_count++;
        $display("Store arrived although the golden model predicts no more stores");
    end

    a_store_addr: assert property (
        @(posedge clk) disable iff (!rst_n)
        (store.we && store_idx < exp_count) |-> (store.addr == head_addr)
    ) else begin
        fail_count++;
        sec_fail[section_of($sampled(head_addr))]++;
        $display("FAILED store.addr expected %h actual %h",
                 $sampled(head_addr), $sampled(store.addr));
    end

    a_store_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        (store.we && store_idx < exp_count) |-> (store.data == head_data)
    ) else begin
        fail_count++;
        sec_fail[section_of($sampled(head_addr))]++;
        $display("FAILED store.data expected %h actual %h",
                 $sampled(head_data), $sampled(store.data));
    end

    a_quiet_after_halt: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |-> !store.we
    ) else begin
        fail_count++;
        halt_fail++;
        $display("A store appeared after the core halted");
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= timeout_limit) begin
                $display("Timeout: the core did not halt within %0d cycles", timeout_limit);
                $display("Test failures found");
                $finish;
            end
        end
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        $readmemh(program_file, prog);
        run_golden();
        timeout_limit = 4 * prog_len + 20;
        repeat (3) @(posedge clk);
        #10 rst_n = 1'b1;

        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        // Watch a few more cycles for stray stores.
        repeat (4) @(negedge clk);

        a_store_count: assert (store_idx == exp_count) else begin
            fail_count++;
            halt_fail++;
            $display("FAILED store count expected %h actual %h", exp_count, store_idx);
        end

        for (int s = 1; s <= 5; s++) begin
            if (sec_fail[s[2:0]] == 0 && sec_seen[s[2:0]] == sec_exp[s[2:0]]) begin
                tests_passed++;
                $display("Test %0d %s: PASS, %0d of %0d stores", s, section_name(s[2:0]),
                         sec_seen[s[2:0]], sec_exp[s[2:0]]);
            end else begin
                tests_failed++;
                $display("Test %0d %s: FAIL, %0d of %0d stores, %0d mismatches", s,
                         section_name(s[2:0]), sec_seen[s[2:0]], sec_exp[s[2:0]],
                         sec_fail[s[2:0]]);
            end
        end
        if (halt_fail == 0) begin
            tests_passed++;
            $display("Test 6 halt: PASS, %0d stores in total", store_idx);
        end else begin
            tests_failed++;
            $display("Test 6 halt: FAIL, %0d of %0d stores", store_idx, exp_count);
        end

        $display("Summary: %0d tests passed, %0d tests failed, %0d check failures",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: writeback_unit.sv
`timescale 1ns/1ns

module writeback_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rv_pkg::wb_t              wb_next,
    output rv_pkg::wb_t              wb_fwd,
    output logic                     rf_we,
    output logic [4:0]               rf_waddr,
    output logic [rv_pkg::xlen-1:0]  rf_wdata,
    output rv_pkg::store_t           store
);
    import rv_pkg::*;

    wb_t wb_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_next;
        end
    end

    // Also feeds execute for forwarding.
    assign wb_fwd = wb_q;

    assign rf_we    = wb_q.valid && wb_q.writes_rd;
    assign rf_waddr = wb_q.rd;
    assign rf_wdata = wb_q.result;

    // Store strobe lasts the single cycle the instruction sits here.
    assign store.we   = wb_q.valid && wb_q.is_store;
    assign store.addr = wb_q.result[xlen-1:2];
    assign store.data = wb_q.store_data;

    // sw never writes a register, whatever the decoder did.
    a_store_no_rf: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(store.we && rf_we)
    ) else $error("store.we and rf_we high together");

endmodule
